//--- hdl/exec_pkg.sv
package exec_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_idx_t; // architectural destination

	// operand A source
	typedef enum logic [1:0] {
		opa_is_rs1  = 2'h0,
		opa_is_npc  = 2'h1,
		opa_is_pc   = 2'h2,
		opa_is_zero = 2'h3
	} opa_select_t;

	// operand B source, codes 6 and 7 unused
	typedef enum logic [2:0] {
		opb_is_rs2   = 3'h0,
		opb_is_i_imm = 3'h1,
		opb_is_s_imm = 3'h2,
		opb_is_b_imm = 3'h3,
		opb_is_u_imm = 3'h4,
		opb_is_j_imm = 3'h5
	} opb_select_t;

	typedef enum logic [3:0] {
		alu_add  = 4'h0,
		alu_sub  = 4'h1,
		alu_slt  = 4'h2,
		alu_sltu = 4'h3,
		alu_and  = 4'h4,
		alu_or   = 4'h5,
		alu_xor  = 4'h6,
		alu_sll  = 4'h7,
		alu_srl  = 4'h8,
		alu_sra  = 4'h9
	} alu_func_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] npc;
		logic [xlen-1:0] inst;          // funct3 picks the branch test
		opa_select_t     opa_select;
		opb_select_t     opb_select;
		alu_func_t       alu_func;
		logic            cond_branch;
		logic            uncond_branch; // jal / jalr
		reg_idx_t        dest_reg;
	} issue_packet_t;

	typedef struct packed {
		logic [xlen-1:0] rs1_value;
		logic [xlen-1:0] rs2_value;
	} operand_pair_t;

	typedef struct packed {
		logic            valid;
		reg_idx_t        dest_reg;
		logic [xlen-1:0] alu_result;
		logic [xlen-1:0] link;        // value to write back
		logic            take_branch;
	} exec_result_t;

	typedef struct packed {
		logic            valid;
		reg_idx_t        dest_reg;
		logic [xlen-1:0] wb_value;
		logic            take_branch;
		logic [xlen-1:0] target;
	} completion_t;

	// sign-extended immediates, one per RV32 format
	function automatic logic [xlen-1:0] i_imm(input logic [xlen-1:0] inst);
		return {{20{inst[31]}}, inst[31:20]};
	endfunction

	function automatic logic [xlen-1:0] s_imm(input logic [xlen-1:0] inst);
		return {{20{inst[31]}}, inst[31:25], inst[11:7]};
	endfunction

	function automatic logic [xlen-1:0] b_imm(input logic [xlen-1:0] inst);
		return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	endfunction

	function automatic logic [xlen-1:0] u_imm(input logic [xlen-1:0] inst);
		return {inst[31:12], 12'b0};
	endfunction

	function automatic logic [xlen-1:0] j_imm(input logic [xlen-1:0] inst);
		return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	endfunction

endpackage

//--- hdl/alu_core.sv
`timescale 1ns/1ps

module alu_core (
	input  logic [exec_pkg::xlen-1:0] opa,
	input  logic [exec_pkg::xlen-1:0] opb,
	input  exec_pkg::alu_func_t       func,
	output logic [exec_pkg::xlen-1:0] result
);
	import exec_pkg::*;

	logic signed [xlen-1:0] opa_s;
	logic signed [xlen-1:0] opb_s;
	logic [4:0]             shamt;

	assign opa_s = opa;
	assign opb_s = opb;
	assign shamt = opb[4:0]; // rv32 shifts ignore upper bits

	always_comb begin
		result = '0;
		case (func)
			alu_add: result = opa + opb;
			alu_sub: result = opa - opb;
			alu_slt: begin
				result = {{(xlen-1){1'b0}}, opa_s < opb_s};
			end
			alu_sltu: begin
				result = {{(xlen-1){1'b0}}, opa < opb};
			end
			alu_and: result = opa & opb;
			alu_or:  result = opa | opb;
			alu_xor: result = opa ^ opb;
			alu_sll: result = opa << shamt;
			alu_srl: result = opa >> shamt;
			alu_sra: result = opa_s >>> shamt; // keeps sign
			default: result = '0;
		endcase
	end

endmodule

//--- hdl/branch_cond.sv
`timescale 1ns/1ps

module branch_cond (
	input  logic [exec_pkg::xlen-1:0] rs1,
	input  logic [exec_pkg::xlen-1:0] rs2,
	input  logic [2:0]                func,
	output logic                      cond
);
	import exec_pkg::*;

	logic signed [xlen-1:0] rs1_s;
	logic signed [xlen-1:0] rs2_s;

	assign rs1_s = rs1;
	assign rs2_s = rs2;

	always_comb begin
		cond = 1'b0;
		case (func)
			3'b000:  cond = (rs1 == rs2);     // beq
			3'b001:  cond = (rs1 != rs2);     // bne
			3'b100:  cond = (rs1_s < rs2_s);  // blt
			3'b101:  cond = (rs1_s >= rs2_s); // bge
			3'b110:  cond = (rs1 < rs2);      // bltu
			3'b111:  cond = (rs1 >= rs2);     // bgeu
			default: cond = 1'b0;             // 010 and 011 are not branches
		endcase
	end

endmodule

//--- hdl/issue_latch.sv
`timescale 1ns/1ps

module issue_latch (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    flush,
	input  logic                    issue_valid,
	input  exec_pkg::issue_packet_t issue,
	input  logic                    ops_ready,
	input  logic                    operand_valid,
	input  exec_pkg::operand_pair_t operands,
	output logic                    busy,
	output exec_pkg::issue_packet_t launch,
	output exec_pkg::operand_pair_t launch_ops
);
	import exec_pkg::*;

	issue_packet_t entry;       // working entry, valid field is the occupancy flag
	operand_pair_t entry_ops;
	logic          ops_held;    // both source values captured
	logic          firing;
	logic          accept;
	logic          late_capture;

	assign firing       = entry.valid && ops_held;
	assign accept       = issue_valid && (!entry.valid || firing); // refill in launch cycle
	assign late_capture = entry.valid && !ops_held && operand_valid;
	assign busy         = entry.valid && !firing;

	// launch only once the entry is complete
	always_comb begin
		launch       = entry;
		launch.valid = firing;
	end

	assign launch_ops = entry_ops;

	always_ff @(posedge clock) begin
		// payload first, occupancy below overrides entry.valid
		if (accept) begin
			entry     <= issue;
			entry_ops <= operands; // garbage when not ready, replaced later
		end else if (late_capture) begin
			entry_ops <= operands;
		end

		if (reset || flush) begin
			entry.valid <= 1'b0;
			ops_held    <= 1'b0;
		end else if (accept) begin
			entry.valid <= 1'b1;
			ops_held    <= ops_ready;
		end else if (firing) begin
			entry.valid <= 1'b0;   // launched, nothing new behind it
			ops_held    <= 1'b0;
		end else if (late_capture) begin
			ops_held <= 1'b1;
		end
	end

endmodule

//--- hdl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    flush,
	input  exec_pkg::issue_packet_t launch,
	input  exec_pkg::operand_pair_t launch_ops,
	output exec_pkg::exec_result_t  exec
);
	import exec_pkg::*;

	logic [xlen-1:0] opa;
	logic [xlen-1:0] opb;
	logic [xlen-1:0] alu_result;
	logic            cond_true;
	logic            take_branch;

	// operand A
	always_comb begin
		opa = '0;
		case (launch.opa_select)
			opa_is_rs1:  opa = launch_ops.rs1_value;
			opa_is_npc:  opa = launch.npc;
			opa_is_pc:   opa = launch.pc;
			opa_is_zero: opa = '0;
			default:     opa = '0;
		endcase
	end

	// operand B, register or decoded immediate
	always_comb begin
		opb = '0; // codes 6 and 7 fall here
		case (launch.opb_select)
			opb_is_rs2:   opb = launch_ops.rs2_value;
			opb_is_i_imm: opb = i_imm(launch.inst);
			opb_is_s_imm: opb = s_imm(launch.inst);
			opb_is_b_imm: opb = b_imm(launch.inst);
			opb_is_u_imm: opb = u_imm(launch.inst);
			opb_is_j_imm: opb = j_imm(launch.inst);
			default:      opb = '0;
		endcase
	end

	alu_core alu_core_inst (
		.opa    (opa),
		.opb    (opb),
		.func   (launch.alu_func),
		.result (alu_result)
	);

	// comparator always sees the register values, not the muxed operands
	branch_cond branch_cond_inst (
		.rs1  (launch_ops.rs1_value),
		.rs2  (launch_ops.rs2_value),
		.func (launch.inst[14:12]), // funct3
		.cond (cond_true)
	);

	assign take_branch = launch.uncond_branch || (launch.cond_branch && cond_true);

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			exec.valid <= 1'b0;
		end else begin
			exec.valid <= launch.valid;
		end

		if (launch.valid) begin
			exec.dest_reg    <= launch.dest_reg;
			exec.alu_result  <= alu_result;  // also the jump/branch target
			exec.take_branch <= take_branch;
			// jumps link npc, everything else writes the alu result
			exec.link        <= launch.uncond_branch ? launch.npc : alu_result;
		end
	end

endmodule

//--- hdl/complete_stage.sv
`timescale 1ns/1ps

module complete_stage (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   flush,
	input  exec_pkg::exec_result_t exec,
	output exec_pkg::completion_t  done
);

	// one cycle pulse per executed instruction
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			done.valid <= 1'b0;
		end else begin
			done.valid <= exec.valid;
		end

		if (exec.valid) begin
			done.dest_reg    <= exec.dest_reg;
			done.wb_value    <= exec.link; // link choice already made upstream
			done.take_branch <= exec.take_branch;
			// redirect only when the branch goes
			done.target      <= exec.take_branch ? exec.alu_result : '0;
		end
	end

endmodule

//--- hdl/exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    flush,
	input  logic                    issue_valid,
	input  exec_pkg::issue_packet_t issue,
	input  logic                    ops_ready,
	input  logic                    operand_valid,
	input  exec_pkg::operand_pair_t operands,
	output logic                    busy,
	output exec_pkg::completion_t   done
);
	import exec_pkg::*;

	issue_packet_t launch;
	operand_pair_t launch_ops;
	exec_result_t  exec;

	issue_latch issue_latch_inst (
		.clock         (clock),
		.reset         (reset),
		.flush         (flush),
		.issue_valid   (issue_valid),
		.issue         (issue),
		.ops_ready     (ops_ready),
		.operand_valid (operand_valid),
		.operands      (operands),
		.busy          (busy),
		.launch        (launch),
		.launch_ops    (launch_ops)
	);

	alu_unit alu_unit_inst (
		.clock      (clock),
		.reset      (reset),
		.flush      (flush),
		.launch     (launch),
		.launch_ops (launch_ops),
		.exec       (exec)
	);

	complete_stage complete_stage_inst (
		.clock (clock),
		.reset (reset),
		.flush (flush),
		.exec  (exec),
		.done  (done)
	);

endmodule

//--- verif/exec_cluster_props.sv
`timescale 1ns/1ps

module exec_cluster_props (
	input logic                    clock,
	input logic                    reset,
	input logic                    flush,
	input logic                    issue_valid,
	input exec_pkg::issue_packet_t issue,
	input logic                    ops_ready,
	input logic                    operand_valid,
	input exec_pkg::operand_pair_t operands,
	input logic                    busy,
	input exec_pkg::completion_t   done,
	input logic [8*16-1:0]         test_name
);
	import exec_pkg::*;

	int            fail_count = 0;
	logic          pending;     // model entry waiting for operands
	issue_packet_t held;
	completion_t   exp_launch;  // expected completion, one stage per DUT register
	completion_t   exp_exec;
	completion_t   exp_done;

	// reference completion for one instruction
	function automatic completion_t model(input issue_packet_t p, input operand_pair_t o);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic        hit;
		completion_t c;
		case (p.opa_select)
			opa_is_rs1: a = o.rs1_value;
			opa_is_npc: a = p.npc;
			opa_is_pc:  a = p.pc;
			default:    a = '0;
		endcase
		case (p.opb_select)
			opb_is_rs2:   b = o.rs2_value;
			opb_is_i_imm: b = i_imm(p.inst);
			opb_is_s_imm: b = s_imm(p.inst);
			opb_is_b_imm: b = b_imm(p.inst);
			opb_is_u_imm: b = u_imm(p.inst);
			opb_is_j_imm: b = j_imm(p.inst);
			default:      b = '0;
		endcase
		case (p.alu_func)
			alu_add:  r = a + b;
			alu_sub:  r = a - b;
			alu_slt:  r = {31'b0, $signed(a) < $signed(b)};
			alu_sltu: r = {31'b0, a < b};
			alu_and:  r = a & b;
			alu_or:   r = a | b;
			alu_xor:  r = a ^ b;
			alu_sll:  r = a << b[4:0];
			alu_srl:  r = a >> b[4:0];
			alu_sra:  r = $signed(a) >>> b[4:0];
			default:  r = '0;
		endcase
		// branch compare always on the register values
		case (p.inst[14:12])
			3'b000:  hit = o.rs1_value == o.rs2_value;
			3'b001:  hit = o.rs1_value != o.rs2_value;
			3'b100:  hit = $signed(o.rs1_value) < $signed(o.rs2_value);
			3'b101:  hit = $signed(o.rs1_value) >= $signed(o.rs2_value);
			3'b110:  hit = o.rs1_value < o.rs2_value;
			3'b111:  hit = o.rs1_value >= o.rs2_value;
			default: hit = 1'b0;
		endcase
		c             = '0;
		c.valid       = 1'b1;
		c.dest_reg    = p.dest_reg;
		c.take_branch = p.uncond_branch || (p.cond_branch && hit);
		c.wb_value    = p.uncond_branch ? p.npc : r; // jumps write the link
		c.target      = c.take_branch ? r : '0;
		return c;
	endfunction

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			pending          <= 1'b0;
			exp_launch.valid <= 1'b0;
			exp_exec.valid   <= 1'b0;
			exp_done.valid   <= 1'b0;
		end else begin
			exp_launch <= '0;
			if (pending && operand_valid) begin
				exp_launch <= model(held, operands);
				pending    <= 1'b0;
			end else if (issue_valid && !pending) begin // dropped while waiting
				if (ops_ready)
					exp_launch <= model(issue, operands);
				held    <= issue;
				pending <= !ops_ready;
			end
			exp_exec <= exp_launch;
			exp_done <= exp_exec;
		end
	end

	a_busy: assert property (@(posedge clock) disable iff (reset) busy == pending)
		else begin
			$error("ERROR %0s: busy expected %b actual %b",
				test_name, $sampled(pending), $sampled(busy));
			fail_count++;
		end

	a_done_valid: assert property (@(posedge clock) disable iff (reset)
		done.valid == exp_done.valid)
		else begin
			$error("ERROR %0s: done.valid expected %b actual %b",
				test_name, $sampled(exp_done.valid), $sampled(done.valid));
			fail_count++;
		end

	a_writeback: assert property (@(posedge clock) disable iff (reset)
		exp_done.valid |-> done.dest_reg == exp_done.dest_reg
			&& done.wb_value == exp_done.wb_value)
		else begin
			$error("ERROR %0s: dest/wb expected %0d/%h actual %0d/%h", test_name,
				$sampled(exp_done.dest_reg), $sampled(exp_done.wb_value),
				$sampled(done.dest_reg), $sampled(done.wb_value));
			fail_count++;
		end

	a_redirect: assert property (@(posedge clock) disable iff (reset)
		exp_done.valid |-> done.take_branch == exp_done.take_branch
			&& done.target == exp_done.target)
		else begin
			$error("ERROR %0s: take/target expected %b/%h actual %b/%h", test_name,
				$sampled(exp_done.take_branch), $sampled(exp_done.target),
				$sampled(done.take_branch), $sampled(done.target));
			fail_count++;
		end

	a_reset_idle: assert property (@(posedge clock) $fell(reset) |-> !busy && !done.valid)
		else begin
			$error("ERROR %0s: busy/done.valid after reset expected 0/0 actual %b/%b",
				test_name, $sampled(busy), $sampled(done.valid));
			fail_count++;
		end

	// nothing issued before the flush may complete
	a_flush_quiet: assert property (@(posedge clock) disable iff (reset)
		flush |=> (!busy && !done.valid) ##1 !done.valid)
		else begin
			$error("ERROR %0s: busy/done.valid after flush expected 0/0 actual %b/%b",
				test_name, $sampled(busy), $sampled(done.valid));
			fail_count++;
		end

endmodule

//--- verif/exec_cluster_tb.sv
`timescale 1ns/1ps

module exec_cluster_tb;
	import exec_pkg::*;

	localparam int period    = 20;
	localparam int ready_ops = 40;
	localparam int late_ops  = 8;
	localparam int branches  = 24;
	localparam int flushes   = 4;
	// late and flush cases take under 10 cycles each, plus drains
	localparam int max_cycles = 10 + ready_ops + 10*late_ops + branches + 10*flushes + 50;
	localparam logic [2:0] branch_funct3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

	logic            clock;
	logic            reset;
	logic            flush;
	logic            issue_valid;
	issue_packet_t   issue;
	logic            ops_ready;
	logic            operand_valid;
	operand_pair_t   operands;
	logic            busy;
	completion_t     done;
	logic [8*16-1:0] test_name;
	logic [31:0]     lfsr;
	int              other_errors;
	int              tests_run;
	int              tests_failed;
	int              fails_at_start;

	exec_cluster exec_cluster_inst (
		.clock         (clock),
		.reset         (reset),
		.flush         (flush),
		.issue_valid   (issue_valid),
		.issue         (issue),
		.ops_ready     (ops_ready),
		.operand_valid (operand_valid),
		.operands      (operands),
		.busy          (busy),
		.done          (done)
	);

	bind exec_cluster exec_cluster_props props_inst (
		.clock         (clock),
		.reset         (reset),
		.flush         (flush),
		.issue_valid   (issue_valid),
		.issue         (issue),
		.ops_ready     (ops_ready),
		.operand_valid (operand_valid),
		.operands      (operands),
		.busy          (busy),
		.done          (done),
		.test_name     (exec_cluster_tb.test_name)
	);

	initial begin
		clock = 1'b0;
		forever #(period/2) clock = ~clock;
	end

	// galois form, taps 32 22 2 1
	function automatic logic next_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic logic [31:0] random_bits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			value = {value[30:0], next_bit()};
		end
		return value;
	endfunction

	function automatic issue_packet_t random_packet();
		issue_packet_t p;
		p            = '0;
		p.valid      = 1'b1;
		p.pc         = random_bits(30) << 2;
		p.npc        = p.pc + 32'd4;
		p.inst       = random_bits(32);
		p.opa_select = opa_select_t'(2'(random_bits(2)));
		p.opb_select = opb_select_t'(3'(random_bits(3) % 6));
		p.alu_func   = alu_func_t'(4'(random_bits(4) % 10));
		p.dest_reg   = 5'(random_bits(5));
		return p;
	endfunction

	function automatic operand_pair_t random_operands();
		operand_pair_t o;
		o.rs1_value = random_bits(32);
		o.rs2_value = next_bit() ? o.rs1_value : random_bits(32); // equal half the time
		return o;
	endfunction

	function automatic issue_packet_t branch_packet(input int i);
		issue_packet_t p;
		p            = random_packet();
		p.alu_func   = alu_add;
		p.opa_select = opa_is_pc;
		if (i % 4 == 3) begin
			p.uncond_branch = 1'b1;
			p.opb_select    = opb_is_j_imm;
			if (i % 8 == 7) begin // jalr form
				p.opa_select = opa_is_rs1;
				p.opb_select = opb_is_i_imm;
			end
		end else begin
			p.cond_branch = 1'b1;
			p.opb_select  = opb_is_b_imm;
			p.inst[14:12] = branch_funct3[i % 6];
		end
		return p;
	endfunction

	task automatic quiet_inputs();
		issue_valid   = 1'b0;
		ops_ready     = 1'b0;
		operand_valid = 1'b0;
		flush         = 1'b0;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			quiet_inputs();
		end
	endtask

	task automatic issue_ready(input issue_packet_t p, input operand_pair_t o);
		@(negedge clock);
		quiet_inputs();
		issue_valid = 1'b1;
		ops_ready   = 1'b1;
		issue       = p;
		operands    = o;
	endtask

	task automatic wait_done(input int limit);
		int waited;
		waited = 0;
		while (!done.valid && waited < limit) begin
			@(negedge clock);
			waited++;
		end
		if (!done.valid) begin
			other_errors++;
			$display("no completion within %0d cycles in test %0s", limit, test_name);
		end
	endtask

	task automatic issue_late();
		int gap;
		gap = 1 + random_bits(2) % 3;
		@(negedge clock);
		quiet_inputs();
		issue_valid = 1'b1;
		issue       = random_packet();
		operands    = random_operands(); // not yet valid
		repeat (gap) begin
			@(negedge clock);
			issue    = random_packet(); // dropped while busy
			operands = random_operands();
		end
		@(negedge clock);
		quiet_inputs();
		operand_valid = 1'b1;
		operands      = random_operands();
		@(negedge clock);
		quiet_inputs();
		wait_done(4);
	endtask

	task automatic flush_pipeline(input logic hold_late);
		repeat (3) begin
			issue_ready(random_packet(), random_operands());
		end
		ops_ready = !hold_late; // last entry may wait in the latch
		@(negedge clock);
		quiet_inputs();
		flush = 1'b1;
		@(negedge clock);
		quiet_inputs();
		operand_valid = hold_late; // nothing left to take it
		idle(3);
	endtask

	task automatic start_test(input logic [8*16-1:0] name);
		test_name      = name;
		fails_at_start = exec_cluster_inst.props_inst.fail_count + other_errors;
	endtask

	task automatic end_test();
		int fails;
		idle(4); // drain the pipeline
		fails = exec_cluster_inst.props_inst.fail_count + other_errors - fails_at_start;
		tests_run++;
		if (fails > 0)
			tests_failed++;
		$display("test %0s finished with %0d failures", test_name, fails);
	endtask

	initial begin
		lfsr         = 32'h156269b1;
		other_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		issue        = '0;
		operands     = '0;
		quiet_inputs();
		reset = 1'b1;
		start_test("reset_state");
		repeat (3) @(negedge clock);
		reset = 1'b0;
		end_test();

		start_test("ready_ops");
		for (int i = 0; i < ready_ops; i++) begin
			issue_ready(random_packet(), random_operands());
			operand_valid = next_bit(); // ignored, nothing waits
		end
		end_test();

		start_test("late_ops");
		for (int i = 0; i < late_ops; i++) begin
			issue_late();
		end
		end_test();

		start_test("branches");
		for (int i = 0; i < branches; i++) begin
			issue_ready(branch_packet(i), random_operands());
		end
		end_test();

		start_test("flush");
		for (int i = 0; i < flushes; i++) begin
			flush_pipeline(i % 2 == 1);
		end
		end_test();

		$display("%0d tests, %0d failed, %0d assertion failures, %0d other errors",
			tests_run, tests_failed, exec_cluster_inst.props_inst.fail_count, other_errors);
		if (exec_cluster_inst.props_inst.fail_count + other_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(max_cycles * period);
		$display("run did not finish within %0d cycles", max_cycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- tb.f
hdl/exec_pkg.sv
hdl/alu_core.sv
hdl/branch_cond.sv
hdl/issue_latch.sv
hdl/alu_unit.sv
hdl/complete_stage.sv
hdl/exec_cluster.sv
verif/exec_cluster_props.sv
verif/exec_cluster_tb.sv
